/* build.f */
hw/cu_pkg.sv
hw/fifo.sv
hw/cu_edge_job_control.sv
hw/cu_vertex_pagerank.sv
hw/cu_pagerank_top.sv
dv/cu_pagerank_tb.sv

/* Bender.yml */
package:
  name: cu_pagerank

sources:
  - files:
      - hw/cu_pkg.sv
      - hw/fifo.sv
      - hw/cu_edge_job_control.sv
      - hw/cu_vertex_pagerank.sv
      - hw/cu_pagerank_top.sv
  - target: simulation
    files:
      - dv/cu_pagerank_tb.sv

/* dv/cu_pagerank_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cu_pagerank_tb import cu_pkg::*; ();

	localparam logic [31:0] SEED       = 32'h5902_a44e;
	localparam logic [31:0] EDGE_BASE  = 32'h0000_1000;
	localparam int          MEM_WORDS  = 256;
	localparam int          NUM_JOBS   = 40;
	localparam int          MAX_INJECT = 24;
	localparam int          NUM_TESTS  = 6;
	localparam int          T_RESET    = 0;
	localparam int          T_CMD      = 1;
	localparam int          T_EDGE     = 2;
	localparam int          T_BP       = 3;
	localparam int          T_ROUTE    = 4;
	localparam int          T_COUNT    = 5;

	logic                        clock;
	logic                        rstn;
	logic                        enabled;
	logic [ADDRESS_BITS-1:0]     edge_base;
	vertex_job_t                 vertex_job;
	buffer_status_t              vertex_buffer_status;
	response_line_t              read_response_in;
	data_line_t                  read_data_in;
	buffer_status_t              read_buffer_status;
	logic                        edge_ready;
	command_line_t               read_command_out;
	logic                        vertex_job_request;
	edge_job_t                   edge_job_out;
	data_line_t                  graph_data_out;
	logic [VERTEX_SIZE_BITS-1:0] vertex_num_counter;

	// generated graph
	logic [31:0] lcg_state;
	logic [31:0] edge_mem [MEM_WORDS];
	logic [31:0] job_ids [NUM_JOBS];
	logic [31:0] job_idx [NUM_JOBS];
	logic [15:0] job_deg [NUM_JOBS];

	// model and scoreboard state
	logic          model_on;
	logic          injecting;
	logic          timed_out;
	logic          vertex_active;
	logic          deliver_pending;
	logic          stalled;
	edge_job_t     held_edge;
	int            cycle;
	int            deliver_at;
	int            jobs_sent;
	int            requests_seen;
	int            vertex_done;
	int            injected;
	int            cur_deg;
	int            exp_lines;
	int            cmds_seen;
	logic [31:0]   cur_id;
	logic [31:0]   cur_idx;
	logic [31:0]   exp_dest [$];
	cmd_tag_t      pend_data_tag [$];
	logic [31:0]   pend_data_addr [$];
	int            pend_data_count [$];
	int            pend_data_time [$];
	cmd_tag_t      pend_resp_tag [$];
	int            pend_resp_time [$];
	data_payload_u graph_q [$];
	int            errs [NUM_TESTS];

	cu_pagerank_top uut (
		.clock               (clock),
		.rstn                (rstn),
		.enabled             (enabled),
		.edge_base           (edge_base),
		.vertex_job          (vertex_job),
		.vertex_buffer_status(vertex_buffer_status),
		.read_response_in    (read_response_in),
		.read_data_in        (read_data_in),
		.read_buffer_status  (read_buffer_status),
		.edge_ready          (edge_ready),
		.read_command_out    (read_command_out),
		.vertex_job_request  (vertex_job_request),
		.edge_job_out        (edge_job_out),
		.graph_data_out      (graph_data_out),
		.vertex_num_counter  (vertex_num_counter)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// model starts on the first falling edge after reset release
	always @(posedge clock) begin
		model_on <= rstn;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int random_below(input int n);
		return int'((next_random() >> 8) % n);
	endfunction

	function automatic string test_name(input int t);
		case (t)
			T_RESET: return "reset";
			T_CMD:   return "commands";
			T_EDGE:  return "edges";
			T_BP:    return "backpressure";
			T_ROUTE: return "routing";
			default: return "vertex_count";
		endcase
	endfunction

	task automatic report_mismatch(input int t, input string what, input logic [127:0] exp,
		input logic [127:0] act);
		$display("error %s %s expected %h actual %h", test_name(t), what, exp, act);
		errs[t]++;
	endtask

	task automatic print_test(input int t);
		$display("test %-12s done with %0d errors", test_name(t), errs[t]);
	endtask

	//////////////////////////////////////////////////
	// scoreboard
	//////////////////////////////////////////////////

	task automatic observe_command();
		logic [31:0] exp_addr;
		int          exp_wc;
		if (read_command_out.valid) begin
			// flag still holds what the DUT saw at the last rising edge
			if (read_buffer_status.alfull) begin
				$display("commands: command issued while the read buffer was almost full");
				errs[T_CMD]++;
			end
			if (!vertex_active || cmds_seen >= exp_lines) begin
				$display("commands: command to %h with no line left to read",
					read_command_out.address);
				errs[T_CMD]++;
			end else begin
				exp_addr = EDGE_BASE + cur_idx + 32'(4 * cmds_seen);
				exp_wc   = cur_deg - 4 * cmds_seen;
				if (exp_wc > CACHELINE_WORDS) begin
					exp_wc = CACHELINE_WORDS;
				end
				if (read_command_out.address !== exp_addr) begin
					report_mismatch(T_CMD, "address", exp_addr, read_command_out.address);
				end
				if (read_command_out.word_count !== WORD_COUNT_BITS'(exp_wc)) begin
					report_mismatch(T_CMD, "word_count", exp_wc, read_command_out.word_count);
				end
				if (read_command_out.cmd.vertex_struct !== EDGE_ARRAY_DEST) begin
					report_mismatch(T_CMD, "structure", EDGE_ARRAY_DEST,
						read_command_out.cmd.vertex_struct);
				end
				if (read_command_out.cmd.line_idx !== LINE_IDX_BITS'(cmds_seen)) begin
					report_mismatch(T_CMD, "line_idx", cmds_seen, read_command_out.cmd.line_idx);
				end
				if (read_command_out.cmd.cu_id !== CU_ID_BITS'(1)) begin
					report_mismatch(T_CMD, "cu_id", 1, read_command_out.cmd.cu_id);
				end
			end
			cmds_seen++;
			// memory answers whatever was asked for
			pend_data_tag.push_back(read_command_out.cmd);
			pend_data_addr.push_back(read_command_out.address);
			pend_data_count.push_back(int'(read_command_out.word_count));
			pend_data_time.push_back(cycle + 1 + random_below(6));
			pend_resp_tag.push_back(read_command_out.cmd);
			pend_resp_time.push_back(cycle + 1 + random_below(6));
		end
	endtask

	task automatic record_edge(input edge_job_t e);
		int n;
		int found;
		if (!vertex_active) begin
			$display("edges: edge job %h with no vertex in progress", e);
			errs[T_EDGE]++;
		end else begin
			if (e.src !== cur_id) begin
				report_mismatch(T_EDGE, "src", cur_id, e.src);
			end
			found = -1;
			for (n = 0; n < exp_dest.size(); n++) begin
				if (found < 0 && exp_dest[n] === e.dest) begin
					found = n;
				end
			end
			if (found < 0) begin
				$display("edges: destination %h is not left in the slice of vertex %h",
					e.dest, cur_id);
				errs[T_EDGE]++;
			end else begin
				exp_dest.delete(found);
			end
		end
	endtask

	// transfer is decided here, half a cycle before the rising edge
	task automatic drive_edge_ready();
		logic ready_next;
		if (stalled && edge_job_out !== held_edge) begin
			report_mismatch(T_BP, "held edge", held_edge, edge_job_out);
		end
		ready_next = (random_below(10) < 7);
		if (edge_job_out.valid && ready_next) begin
			record_edge(edge_job_out);
		end
		stalled    = edge_job_out.valid && !ready_next;
		held_edge  = edge_job_out;
		edge_ready = ready_next;
	endtask

	task automatic check_graph_data();
		if (graph_data_out.valid) begin
			if (graph_q.size() == 0) begin
				$display("routing: graph data output with tag %h but no graph line pending",
					graph_data_out.cmd);
				errs[T_ROUTE]++;
			end else begin
				if (graph_data_out.cmd.vertex_struct !== GRAPH_DATA) begin
					report_mismatch(T_ROUTE, "structure", GRAPH_DATA,
						graph_data_out.cmd.vertex_struct);
				end
				if (graph_data_out.payload !== graph_q[0]) begin
					report_mismatch(T_ROUTE, "payload", graph_q[0], graph_data_out.payload);
				end
				void'(graph_q.pop_front());
			end
		end
	endtask

	//////////////////////////////////////////////////
	// vertex buffer and memory models
	//////////////////////////////////////////////////

	task automatic handle_request();
		if (vertex_job_request) begin
			requests_seen++;
			// a request after a job marks that vertex complete
			if (vertex_active) begin
				if (cmds_seen != exp_lines) begin
					report_mismatch(T_CMD, "command count", exp_lines, cmds_seen);
				end
				if (exp_dest.size() != 0) begin
					report_mismatch(T_EDGE, "edges left", 0, exp_dest.size());
				end
				vertex_active = 1'b0;
				vertex_done++;
			end
			if (jobs_sent < NUM_JOBS) begin
				deliver_pending = 1'b1;
				deliver_at      = cycle + 1 + random_below(3);
			end else begin
				vertex_buffer_status.empty = 1'b1;
				vertex_buffer_status.valid = 1'b0;
			end
		end
	endtask

	task automatic drive_vertex_job();
		int n;
		vertex_job = '0;
		if (deliver_pending && cycle >= deliver_at) begin
			vertex_job.valid      = 1'b1;
			vertex_job.id         = job_ids[jobs_sent];
			vertex_job.edges_idx  = job_idx[jobs_sent];
			vertex_job.out_degree = job_deg[jobs_sent];
			cur_id    = job_ids[jobs_sent];
			cur_idx   = job_idx[jobs_sent];
			cur_deg   = int'(job_deg[jobs_sent]);
			exp_lines = (cur_deg + CACHELINE_WORDS - 1) / CACHELINE_WORDS;
			cmds_seen = 0;
			exp_dest.delete();
			for (n = 0; n < cur_deg; n++) begin
				exp_dest.push_back(edge_mem[int'(cur_idx) + n]);
			end
			vertex_active   = 1'b1;
			deliver_pending = 1'b0;
			jobs_sent++;
		end
	endtask

	task automatic drive_returns();
		int             n;
		int             di;
		int             ri;
		int             mem_index;
		data_line_t     line;
		response_line_t resp;
		di   = -1;
		ri   = -1;
		line = '0;
		resp = '0;
		for (n = 0; n < pend_resp_time.size(); n++) begin
			if (ri < 0 && pend_resp_time[n] <= cycle) begin
				ri = n;
			end
		end
		for (n = 0; n < pend_data_time.size(); n++) begin
			if (di < 0 && pend_data_time[n] <= cycle) begin
				di = n;
			end
		end
		if (ri >= 0) begin
			resp.valid = 1'b1;
			resp.cmd   = pend_resp_tag[ri];
			pend_resp_tag.delete(ri);
			pend_resp_time.delete(ri);
		end
		if (di >= 0) begin
			line.valid = 1'b1;
			line.cmd   = pend_data_tag[di];
			// words past the count are junk and must be skipped
			for (n = 0; n < CACHELINE_WORDS; n++) begin
				mem_index = int'(pend_data_addr[di] - EDGE_BASE) + n;
				if (n < pend_data_count[di]) begin
					line.payload.vertex_id[n] = edge_mem[mem_index % MEM_WORDS];
				end else begin
					line.payload.vertex_id[n] = next_random();
				end
			end
			pend_data_tag.delete(di);
			pend_data_addr.delete(di);
			pend_data_count.delete(di);
			pend_data_time.delete(di);
		end else if (injecting && injected < MAX_INJECT && random_below(16) == 0) begin
			line.valid        = 1'b1;
			line.cmd.cu_id    = CU_ID_BITS'(1);
			line.cmd.line_idx = LINE_IDX_BITS'(random_below(64));
			for (n = 0; n < CACHELINE_WORDS; n++) begin
				line.payload.rank[n] = next_random();
			end
			if (random_below(2) == 0) begin
				line.cmd.vertex_struct = GRAPH_DATA;
				graph_q.push_back(line.payload);
			end else begin
				line.cmd.vertex_struct = STRUCT_NONE;
			end
			injected++;
		end
		read_response_in          = resp;
		read_data_in              = line;
		read_buffer_status.alfull = (pend_data_time.size() >= 2);
		read_buffer_status.empty  = (pend_data_time.size() == 0);
		read_buffer_status.valid  = (pend_data_time.size() != 0);
	endtask

	always @(negedge clock) begin
		if (model_on) begin
			cycle++;
			observe_command();
			drive_edge_ready();
			check_graph_data();
			handle_request();
			drive_vertex_job();
			drive_returns();
		end
	end

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		int n;
		int waited;
		int clean;
		lcg_state            = SEED;
		rstn                 = 1'b0;
		enabled              = 1'b1;
		edge_base            = EDGE_BASE;
		vertex_job           = '0;
		vertex_buffer_status = '0;
		vertex_buffer_status.empty = 1'b1;
		read_response_in     = '0;
		read_data_in         = '0;
		read_buffer_status   = '0;
		read_buffer_status.empty = 1'b1;
		edge_ready           = 1'b0;
		injecting            = 1'b1;
		timed_out            = 1'b0;
		vertex_active        = 1'b0;
		deliver_pending      = 1'b0;
		stalled              = 1'b0;
		held_edge            = '0;
		cycle                = 0;
		deliver_at           = 0;
		jobs_sent            = 0;
		requests_seen        = 0;
		vertex_done          = 0;
		injected             = 0;
		cur_deg              = 0;
		exp_lines            = 0;
		cmds_seen            = 0;
		cur_id               = '0;
		cur_idx              = '0;
		for (n = 0; n < NUM_TESTS; n++) begin
			errs[n] = 0;
		end
		for (n = 0; n < MEM_WORDS; n++) begin
			edge_mem[n] = next_random();
		end
		for (n = 0; n < NUM_JOBS; n++) begin
			job_ids[n] = next_random();
			job_idx[n] = 32'(random_below(200));
			job_deg[n] = 16'(random_below(12));
		end

		repeat (16) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		if (read_command_out.valid !== 1'b0) begin
			report_mismatch(T_RESET, "command valid", 0, read_command_out.valid);
		end
		if (edge_job_out.valid !== 1'b0) begin
			report_mismatch(T_RESET, "edge valid", 0, edge_job_out.valid);
		end
		if (graph_data_out.valid !== 1'b0) begin
			report_mismatch(T_RESET, "graph valid", 0, graph_data_out.valid);
		end
		if (vertex_num_counter !== '0) begin
			report_mismatch(T_RESET, "vertex_num_counter", 0, vertex_num_counter);
		end

		// request must wait for the vertex buffer
		repeat (4) @(posedge clock);
		if (requests_seen != 0) begin
			$display("reset: vertex job request while the vertex buffer was empty");
			errs[T_RESET]++;
		end
		@(negedge clock);
		vertex_buffer_status.empty = 1'b0;
		vertex_buffer_status.valid = 1'b1;

		waited = 0;
		while (requests_seen < 1 && waited < 50) begin
			@(posedge clock);
			waited++;
		end
		if (requests_seen < 1) begin
			$display("reset: no vertex job request within 50 cycles of the vertex buffer filling");
			errs[T_RESET]++;
			timed_out = 1'b1;
		end
		print_test(T_RESET);

		if (!timed_out) begin
			waited = 0;
			while (vertex_done < NUM_JOBS && waited < 20000) begin
				@(posedge clock);
				waited++;
			end
			if (vertex_done < NUM_JOBS) begin
				$display("timeout: only %0d of %0d vertices completed", vertex_done, NUM_JOBS);
				timed_out = 1'b1;
			end
		end
		injecting = 1'b0;

		// let injected graph lines drain out
		if (!timed_out) begin
			waited = 0;
			while (graph_q.size() != 0 && waited < 200) begin
				@(posedge clock);
				waited++;
			end
			if (graph_q.size() != 0) begin
				report_mismatch(T_ROUTE, "graph lines missing", 0, graph_q.size());
			end
			repeat (8) @(posedge clock);
		end

		@(negedge clock);
		if (vertex_num_counter !== 32'(NUM_JOBS)) begin
			report_mismatch(T_COUNT, "vertex_num_counter", NUM_JOBS, vertex_num_counter);
		end
		if (timed_out) begin
			errs[T_COUNT]++;
		end
		for (n = T_CMD; n < NUM_TESTS; n++) begin
			print_test(n);
		end
		clean = 0;
		for (n = 0; n < NUM_TESTS; n++) begin
			if (errs[n] == 0) begin
				clean++;
			end
		end
		$display("tests %0d, clean %0d, with errors %0d, graph lines %0d",
			NUM_TESTS, clean, NUM_TESTS - clean, injected);
		if (clean == NUM_TESTS && !timed_out) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hw/cu_pagerank_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cu_pagerank_top import cu_pkg::*; (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  logic [ADDRESS_BITS-1:0]     edge_base,
	input  vertex_job_t                 vertex_job,
	input  buffer_status_t              vertex_buffer_status,
	input  response_line_t              read_response_in,
	input  data_line_t                  read_data_in,
	input  buffer_status_t              read_buffer_status,
	input  logic                        edge_ready,
	output command_line_t               read_command_out,
	output logic                        vertex_job_request,
	output edge_job_t                   edge_job_out,
	output data_line_t                  graph_data_out,
	output logic [VERTEX_SIZE_BITS-1:0] vertex_num_counter
);

	// single compute unit, id 1
	cu_vertex_pagerank #(
		.CU_ID     (1),
		.FIFO_DEPTH(16)
	) vertex_pagerank (
		.clock               (clock),
		.rstn                (rstn),
		.enabled             (enabled),
		.edge_base           (edge_base),
		.vertex_job          (vertex_job),
		.vertex_buffer_status(vertex_buffer_status),
		.read_response_in    (read_response_in),
		.read_data_in        (read_data_in),
		.read_buffer_status  (read_buffer_status),
		.edge_ready          (edge_ready),
		.read_command_out    (read_command_out),
		.vertex_job_request  (vertex_job_request),
		.edge_job_out        (edge_job_out),
		.graph_data_out      (graph_data_out),
		.vertex_num_counter  (vertex_num_counter)
	);

endmodule

`default_nettype wire

/* hw/cu_vertex_pagerank.sv */
`timescale 1ns/10ps
`default_nettype none

module cu_vertex_pagerank import cu_pkg::*; #(
	parameter logic [CU_ID_BITS-1:0] CU_ID      = 1,
	parameter int                    FIFO_DEPTH = 16
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  logic [ADDRESS_BITS-1:0]     edge_base,
	input  vertex_job_t                 vertex_job,
	input  buffer_status_t              vertex_buffer_status,
	input  response_line_t              read_response_in,
	input  data_line_t                  read_data_in,
	input  buffer_status_t              read_buffer_status,
	input  logic                        edge_ready,
	output command_line_t               read_command_out,
	output logic                        vertex_job_request,
	output edge_job_t                   edge_job_out,
	output data_line_t                  graph_data_out,
	output logic [VERTEX_SIZE_BITS-1:0] vertex_num_counter
);

	// vertex intake
	vertex_job_t    vertex_job_latched;
	logic           job_accept;
	logic           processing_vertex;
	logic           request_pending;
	logic           request_send;
	logic           edge_request;

	// registered inputs and edge control side
	response_line_t read_response_in_latched;
	data_line_t     read_data_in_latched;
	command_line_t  read_command_latched;
	response_line_t response_in_edge_job;
	data_line_t     data_in_edge_job;
	logic           edge_data_ready;

	// buffers
	buffer_status_t response_buffer_status;
	buffer_status_t data_buffer_status;
	response_line_t response_head;
	data_line_t     data_head;
	logic           response_pop;
	logic           data_pop;
	logic           data_head_is_edge;
	logic           data_head_is_graph;

	//////////////////////////////////////////////////
	// input and output registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			read_response_in_latched <= '0;
			read_data_in_latched     <= '0;
		end else if (enabled) begin
			read_response_in_latched <= read_response_in;
			read_data_in_latched     <= read_data_in;
		end else begin
			read_response_in_latched <= '0;
			read_data_in_latched     <= '0;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			read_command_out   <= '0;
			vertex_job_request <= 1'b0;
		end else begin
			read_command_out   <= read_command_latched;
			vertex_job_request <= request_send;
		end
	end

	//////////////////////////////////////////////////
	// vertex job intake
	//////////////////////////////////////////////////

	// jobs arriving mid-vertex are ignored
	assign job_accept = enabled & vertex_job.valid & ~processing_vertex;

	// one request per completed vertex, held until the buffer has work
	assign request_send = enabled & request_pending & ~processing_vertex
		& ~vertex_buffer_status.empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			vertex_job_latched <= '0;
		end else begin
			vertex_job_latched.valid <= 1'b0;
			if (job_accept) begin
				vertex_job_latched <= vertex_job;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			vertex_num_counter <= '0;
			processing_vertex  <= 1'b0;
			request_pending    <= 1'b0;
		end else if (enabled) begin
			if (job_accept) begin
				vertex_num_counter <= vertex_num_counter + 1'b1;
				processing_vertex  <= 1'b1;
			end else if (edge_request) begin
				processing_vertex <= 1'b0;
			end
			if (edge_request) begin
				request_pending <= 1'b1;
			end else if (request_send) begin
				request_pending <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// edge job control
	//////////////////////////////////////////////////

	cu_edge_job_control #(
		.CU_ID(CU_ID)
	) edge_job_control (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.edge_base         (edge_base),
		.vertex_job        (vertex_job_latched),
		.read_response_in  (response_in_edge_job),
		.read_data_in      (data_in_edge_job),
		.read_buffer_status(read_buffer_status),
		.edge_ready        (edge_ready),
		.read_command_out  (read_command_latched),
		.data_ready        (edge_data_ready),
		.edge_job          (edge_job_out),
		.vertex_job_request(edge_request)
	);

	//////////////////////////////////////////////////
	// routing by structure tag
	//////////////////////////////////////////////////

	assign data_head_is_edge  = is_edge_array(data_head.cmd.vertex_struct);
	assign data_head_is_graph = (data_head.cmd.vertex_struct == GRAPH_DATA);

	// strictly in order, so a stalled edge line blocks graph data behind it
	assign response_pop = enabled & response_buffer_status.valid;
	assign data_pop     = enabled & ~data_buffer_status.empty
		& (~data_head_is_edge | edge_data_ready);

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			response_in_edge_job <= '0;
			data_in_edge_job     <= '0;
			graph_data_out       <= '0;
		end else begin
			response_in_edge_job <= '0;
			data_in_edge_job     <= '0;
			graph_data_out       <= '0;
			if (response_pop && is_edge_array(response_head.cmd.vertex_struct)) begin
				response_in_edge_job <= response_head;
			end
			// STRUCT_NONE and unused tags fall through and are dropped
			if (data_pop && data_head_is_edge) begin
				data_in_edge_job <= data_head;
			end else if (data_pop && data_head_is_graph) begin
				graph_data_out <= data_head;
			end
		end
	end

	//////////////////////////////////////////////////
	// response and data buffers
	//////////////////////////////////////////////////

	fifo #(
		.WIDTH($bits(response_line_t)),
		.DEPTH(FIFO_DEPTH)
	) response_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (read_response_in_latched.valid),
		.data_in (read_response_in_latched),
		.pop     (response_pop),
		.data_out(response_head),
		.full    (response_buffer_status.full),
		.alfull  (response_buffer_status.alfull),
		.empty   (response_buffer_status.empty),
		.valid   (response_buffer_status.valid)
	);

	fifo #(
		.WIDTH($bits(data_line_t)),
		.DEPTH(FIFO_DEPTH)
	) data_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (read_data_in_latched.valid),
		.data_in (read_data_in_latched),
		.pop     (data_pop),
		.data_out(data_head),
		.full    (data_buffer_status.full),
		.alfull  (data_buffer_status.alfull),
		.empty   (data_buffer_status.empty),
		.valid   (data_buffer_status.valid)
	);

endmodule

`default_nettype wire

/* hw/cu_edge_job_control.sv */
`timescale 1ns/10ps
`default_nettype none

module cu_edge_job_control import cu_pkg::*; #(
	parameter logic [CU_ID_BITS-1:0] CU_ID = 1
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled,
	input  logic [ADDRESS_BITS-1:0] edge_base,
	input  vertex_job_t             vertex_job,
	input  response_line_t          read_response_in,
	input  data_line_t              read_data_in,
	input  buffer_status_t          read_buffer_status,
	input  logic                    edge_ready,
	output command_line_t           read_command_out,
	output logic                    data_ready,
	output edge_job_t               edge_job,
	output logic                    vertex_job_request
);

	localparam int WORD_IDX_BITS = $clog2(CACHELINE_WORDS);

	// current vertex
	vertex_job_t              job;
	logic                     active;
	logic                     boot;
	logic [DEGREE_BITS:0]     degree_round;
	logic [LINE_IDX_BITS:0]   num_lines;
	logic [LINE_IDX_BITS:0]   cmd_count;
	logic [LINE_IDX_BITS:0]   resp_count;
	logic [DEGREE_BITS-1:0]   edge_count;
	logic [DEGREE_BITS:0]     words_left;
	logic                     issue;
	logic                     complete;

	// line holder
	logic                     hold_valid;
	data_payload_u            hold_line;
	logic [LINE_IDX_BITS-1:0] hold_line_idx;
	logic [WORD_IDX_BITS-1:0] word_idx;
	logic                     word_used;
	logic                     edge_fire;

	//////////////////////////////////////////////////
	// read commands
	//////////////////////////////////////////////////

	// one line per CACHELINE_WORDS edges, rounded up
	assign degree_round = {1'b0, job.out_degree} + (DEGREE_BITS + 1)'(CACHELINE_WORDS - 1);
	assign num_lines    = degree_round[DEGREE_BITS:WORD_IDX_BITS];
	assign words_left   = {1'b0, job.out_degree} - {cmd_count, {WORD_IDX_BITS{1'b0}}};

	assign issue = enabled & active & (cmd_count < num_lines) & ~read_buffer_status.alfull;

	always_comb begin
		read_command_out         = '0;
		read_command_out.valid   = issue;
		read_command_out.address = edge_base + job.edges_idx
			+ ADDRESS_BITS'({cmd_count, {WORD_IDX_BITS{1'b0}}});
		// last line may be short
		if (words_left >= (DEGREE_BITS + 1)'(CACHELINE_WORDS)) begin
			read_command_out.word_count = WORD_COUNT_BITS'(CACHELINE_WORDS);
		end else begin
			read_command_out.word_count = words_left[WORD_COUNT_BITS-1:0];
		end
		read_command_out.cmd.cu_id         = CU_ID;
		read_command_out.cmd.vertex_struct = EDGE_ARRAY_DEST;
		read_command_out.cmd.line_idx      = cmd_count[LINE_IDX_BITS-1:0];
	end

	//////////////////////////////////////////////////
	// vertex bookkeeping
	//////////////////////////////////////////////////

	// done once every response is back and every edge has left
	assign complete = enabled & active & ~hold_valid
		& (cmd_count == num_lines) & (resp_count == num_lines)
		& (edge_count == job.out_degree);

	assign vertex_job_request = enabled & (boot | complete);

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			job        <= '0;
			active     <= 1'b0;
			boot       <= 1'b1;
			cmd_count  <= '0;
			resp_count <= '0;
			edge_count <= '0;
		end else if (enabled) begin
			boot <= 1'b0;
			if (vertex_job.valid) begin
				job        <= vertex_job;
				active     <= 1'b1;
				cmd_count  <= '0;
				resp_count <= '0;
				edge_count <= '0;
			end else begin
				if (complete) begin
					active <= 1'b0;
				end
				if (issue) begin
					cmd_count <= cmd_count + 1'b1;
				end
				if (read_response_in.valid) begin
					resp_count <= resp_count + 1'b1;
				end
				if (edge_fire) begin
					edge_count <= edge_count + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// line holder and edge unpacking
	//////////////////////////////////////////////////

	// a line already on its way counts as occupying the holder
	assign data_ready = ~hold_valid & ~read_data_in.valid;

	assign word_used = ({hold_line_idx, word_idx} < job.out_degree);

	assign edge_job.valid = enabled & hold_valid & word_used;
	assign edge_job.src   = job.id;
	assign edge_job.dest  = hold_line.vertex_id[word_idx];

	assign edge_fire = edge_job.valid & edge_ready;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			hold_valid    <= 1'b0;
			hold_line_idx <= '0;
			word_idx      <= '0;
		end else if (enabled) begin
			if (hold_valid) begin
				// words past out_degree end the line early
				if (!word_used) begin
					hold_valid <= 1'b0;
				end else if (edge_fire) begin
					word_idx <= word_idx + 1'b1;
					if (word_idx == WORD_IDX_BITS'(CACHELINE_WORDS - 1)) begin
						hold_valid <= 1'b0;
					end
				end
			end else if (read_data_in.valid) begin
				hold_valid    <= 1'b1;
				hold_line_idx <= read_data_in.cmd.line_idx;
				word_idx      <= '0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (enabled && !hold_valid && read_data_in.valid) begin
			hold_line <= read_data_in.payload;
		end
	end

endmodule

`default_nettype wire

/* hw/fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty,
	output logic             valid
);

	localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]      mem [DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// push on full and pop on empty are dropped
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	assign empty  = (count == '0);
	assign full   = (count == COUNT_BITS'(DEPTH));
	assign alfull = (count >= COUNT_BITS'(DEPTH - 2));
	assign valid  = ~empty;

	// head is visible without a pop
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (!do_push && do_pop) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

endmodule

`default_nettype wire

/* hw/cu_pkg.sv */
`default_nettype none

package cu_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////

	localparam int CACHELINE_WORDS  = 4;
	localparam int VERTEX_SIZE_BITS = 32;
	localparam int RANK_BITS        = 32;
	localparam int ADDRESS_BITS     = 32;
	localparam int CU_ID_BITS       = 3;
	localparam int LINE_IDX_BITS    = 14;
	localparam int WORD_COUNT_BITS  = 3;
	localparam int DEGREE_BITS      = 16;

	//////////////////////////////////////////////////
	// command tags
	//////////////////////////////////////////////////

	// which graph structure a read targets
	typedef enum logic [2:0] {
		EDGE_ARRAY_SRC,
		EDGE_ARRAY_DEST,
		EDGE_ARRAY_WEIGHT,
		INV_EDGE_ARRAY_SRC,
		INV_EDGE_ARRAY_DEST,
		INV_EDGE_ARRAY_WEIGHT,
		GRAPH_DATA,
		STRUCT_NONE
	} vertex_struct_t;

	typedef struct packed {
		logic [CU_ID_BITS-1:0]    cu_id;
		vertex_struct_t           vertex_struct;
		logic [LINE_IDX_BITS-1:0] line_idx;
	} cmd_tag_t;

	//////////////////////////////////////////////////
	// memory side lines
	//////////////////////////////////////////////////

	typedef struct packed {
		logic                       valid;
		logic [ADDRESS_BITS-1:0]    address;
		logic [WORD_COUNT_BITS-1:0] word_count;
		cmd_tag_t                   cmd;
	} command_line_t;

	typedef struct packed {
		logic     valid;
		cmd_tag_t cmd;
	} response_line_t;

	// edge arrays hold vertex ids, graph data holds fixed-point ranks
	typedef union packed {
		logic [CACHELINE_WORDS-1:0][VERTEX_SIZE_BITS-1:0] vertex_id;
		logic [CACHELINE_WORDS-1:0][RANK_BITS-1:0]        rank;
	} data_payload_u;

	typedef struct packed {
		logic          valid;
		cmd_tag_t      cmd;
		data_payload_u payload;
	} data_line_t;

	//////////////////////////////////////////////////
	// jobs and buffer flags
	//////////////////////////////////////////////////

	typedef struct packed {
		logic                        valid;
		logic [VERTEX_SIZE_BITS-1:0] id;
		logic [VERTEX_SIZE_BITS-1:0] edges_idx;
		logic [DEGREE_BITS-1:0]      out_degree;
	} vertex_job_t;

	typedef struct packed {
		logic                        valid;
		logic [VERTEX_SIZE_BITS-1:0] src;
		logic [VERTEX_SIZE_BITS-1:0] dest;
	} edge_job_t;

	typedef struct packed {
		logic valid;
		logic empty;
		logic full;
		logic alfull;
	} buffer_status_t;

	// every edge-array flavour goes to edge job control
	function automatic logic is_edge_array(input vertex_struct_t vertex_struct);
		case (vertex_struct)
			EDGE_ARRAY_SRC, EDGE_ARRAY_DEST, EDGE_ARRAY_WEIGHT,
			INV_EDGE_ARRAY_SRC, INV_EDGE_ARRAY_DEST, INV_EDGE_ARRAY_WEIGHT: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire
